// ==== verilog.f ====
hdl/spike_filter_pkg.sv
hdl/filter_state_mem.sv
hdl/tag_coalescer.sv
hdl/update_timer.sv
hdl/spike_filter_array.sv
hdl/spike_rate_unit.sv
sim/spike_rate_checker.sv
sim/spike_rate_unit_tb.sv

// ==== sim/spike_rate_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spike_rate_unit_tb;
  import spike_filter_pkg::*;

  localparam int clk_period = 20;
  localparam int reset_cycles = 10;
  localparam int drive_delay = 2;
  localparam int sweep_period = 2000;
  localparam int sweep_timeout = 3 * sweep_period;
  localparam int offer_timeout = 200;
  // decay mode constants give 10.0 per spike and about 0.999 per sweep
  localparam int inc_decay = 5120;
  localparam int decay_keep = 134083577;

  logic clk;
  logic reset;
  spike_tag_t spike_in;
  logic spike_valid;
  logic spike_ready;
  filter_cfg_t cfg;
  logic [period_w-1:0] update_period;
  filter_out_t rate_out;
  logic rate_valid;
  logic rate_ready;

  integer seed;
  // random rate_ready lows when set
  logic stall_on;
  // rate_ready for the coming cycle, drawn at the falling edge
  logic ready_next;
  int error_count;
  int rate_count;
  int sweep_count;
  int test_num;
  int tests_bad;
  int errors_at_start;
  string test_name;

  spike_rate_unit uut (
    .clk           (clk),
    .reset         (reset),
    .spike_in      (spike_in),
    .spike_valid   (spike_valid),
    .spike_ready   (spike_ready),
    .cfg           (cfg),
    .update_period (update_period),
    .rate_out      (rate_out),
    .rate_valid    (rate_valid),
    .rate_ready    (rate_ready)
  );

  spike_rate_checker chk (
    .clk         (clk),
    .reset       (reset),
    .spike_in    (spike_in),
    .spike_valid (spike_valid),
    .spike_ready (spike_ready),
    .cfg         (cfg),
    .rate_out    (rate_out),
    .rate_valid  (rate_valid),
    .rate_ready  (rate_ready),
    .error_count (error_count),
    .rate_count  (rate_count),
    .sweep_count (sweep_count)
  );

  always #(clk_period / 2) clk = !clk;

  // output back-pressure on about one cycle in four
  always @(negedge clk) begin
    if (stall_on)
      ready_next = (($random(seed) & 3) != 0);
    else
      ready_next = 1'b1;
  end

  always @(posedge clk) begin
    #drive_delay;
    rate_ready <= ready_next;
  end

  ////////////////////////////////////////
  // stimulus helpers

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  task automatic set_cfg(input int used, input int inc, input int decay);
    cfg.filts_used = used;
    cfg.increment_constant = inc;
    cfg.decay_constant = decay;
  endtask

  // hold one spike until the coalescer takes it
  task automatic offer_spike(input int tag);
    int waited;
    logic taken;
    spike_in.tag = tag;
    spike_valid = 1'b1;
    taken = 1'b0;
    waited = 0;
    while (!taken) begin
      @(negedge clk);
      taken = spike_ready;
      next_cycle();
      waited++;
      if (!taken && waited > offer_timeout)
        stop_on_timeout("spike_ready");
    end
    spike_valid = 1'b0;
  endtask

  // 20 to 60 offers of tags 0..31 with repeats and idle gaps mixed in
  task automatic send_burst();
    int offers;
    int tag;
    offers = 20 + $unsigned($random(seed)) % 41;
    tag = 0;
    for (int i = 0; i < offers; i++) begin
      if (i == 0 || ($random(seed) & 1))
        tag = $unsigned($random(seed)) % 32;
      offer_spike(tag);
      if (($random(seed) & 3) == 0)
        next_cycle();
    end
  endtask

  task automatic wait_sweep_end();
    int start_count;
    int waited;
    start_count = sweep_count;
    waited = 0;
    while (sweep_count == start_count) begin
      next_cycle();
      waited++;
      if (waited > sweep_timeout)
        stop_on_timeout("the end of a decay sweep");
    end
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, test_name,
               error_count - errors_at_start);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    seed = 55237;
    clk = 1'b0;
    reset = 1'b1;
    spike_in = '0;
    spike_valid = 1'b0;
    rate_ready = 1'b1;
    stall_on = 1'b0;
    update_period = sweep_period;
    set_cfg(24, 1, 0);
    test_num = 0;
    tests_bad = 0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    // first sweep follows the memory clear and reports zeros
    wait_sweep_end();

    // bursts always start right after a sweep's last output
    begin_test("count mode");
    repeat (3) begin
      send_burst();
      wait_sweep_end();
    end
    end_test();

    begin_test("filters off");
    set_cfg(0, 1, 0);
    send_burst();
    idle_cycles(2 * sweep_period);
    // re-enable and line up with the next sweep again
    set_cfg(24, 1, 0);
    wait_sweep_end();
    set_cfg(12, 1, 0);
    send_burst();
    wait_sweep_end();
    end_test();

    begin_test("decay mode");
    set_cfg(24, inc_decay, decay_keep);
    repeat (4) begin
      send_burst();
      wait_sweep_end();
    end
    end_test();

    begin_test("bursts");
    set_cfg(24, 1, 0);
    // one tag past max_ct followed by alternating tags
    repeat (1100) offer_spike(5);
    for (int i = 0; i < 40; i++)
      offer_spike((i % 2) ? 6 : 7);
    wait_sweep_end();
    send_burst();
    wait_sweep_end();
    end_test();

    begin_test("back-pressure");
    stall_on = 1'b1;
    set_cfg(24, inc_decay, decay_keep);
    repeat (4) begin
      send_burst();
      wait_sweep_end();
    end
    stall_on = 1'b0;
    end_test();

    $display("%0d tests, %0d with errors, %0d rate outputs, %0d errors in total",
             test_num, tests_bad, rate_count, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/spike_rate_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

// reference model of all filter states
// samples at the falling edge, so every transfer seen here lands on the next rising edge
module spike_rate_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  spike_filter_pkg::spike_tag_t  spike_in,
  input  logic                          spike_valid,
  input  logic                          spike_ready,
  input  spike_filter_pkg::filter_cfg_t cfg,
  input  spike_filter_pkg::filter_out_t rate_out,
  input  logic                          rate_valid,
  input  logic                          rate_ready,
  output int                            error_count,
  output int                            rate_count,
  output int                            sweep_count
);
  import spike_filter_pkg::*;

  // one 18.9 state per filter
  logic [state_w-1:0] model [max_filts];
  // 0.27 times 18.9 gives 18.36
  logic [2*state_w-1:0] product;
  // next index the sweep must report
  int exp_idx;
  // output presented but not taken last cycle
  logic held;
  filter_out_t held_out;

  initial begin
    error_count = 0;
    rate_count = 0;
    sweep_count = 0;
  end

  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < max_filts; i++)
        model[i] = '0;
      exp_idx = 0;
      held = 1'b0;
    end else begin
      ////////////////////////////////////////
      // stalled output must hold still
      if (held) begin
        if (!rate_valid) begin
          $display("rate_valid dropped before rate_out was accepted");
          error_count++;
        end else if (rate_out !== held_out) begin
          $display("MISMATCH rate_out held: expected %h, got %h", held_out, rate_out);
          error_count++;
        end
      end
      held = rate_valid && !rate_ready;
      held_out = rate_out;

      ////////////////////////////////////////
      // spikes of filters in use add the increment, truncated to 27 bits
      if (spike_valid && spike_ready && (spike_in.tag < cfg.filts_used))
        model[spike_in.tag] = model[spike_in.tag] + cfg.increment_constant;

      ////////////////////////////////////////
      // each accepted rate report
      if (rate_valid && rate_ready) begin
        rate_count++;
        if (exp_idx >= cfg.filts_used) begin
          $display("rate output %h with no filter left to report", rate_out);
          error_count++;
        end else begin
          if (rate_out.filt_idx !== exp_idx) begin
            $display("MISMATCH rate_out.filt_idx: expected %h, got %h",
                     exp_idx[filt_idx_w-1:0], rate_out.filt_idx);
            error_count++;
          end
          if (rate_out.filt_state !== model[exp_idx]) begin
            $display("MISMATCH rate_out.filt_state filter %0d: expected %h, got %h",
                     exp_idx, model[exp_idx], rate_out.filt_state);
            error_count++;
          end
          // decay keeps the upper 27 bits of the product
          product = cfg.decay_constant * model[exp_idx];
          model[exp_idx] = product[2*state_w-1:state_w];
          if (exp_idx + 1 >= cfg.filts_used) begin
            exp_idx = 0;
            sweep_count++;
          end else begin
            exp_idx++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spike_rate_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

// spike rate estimator top level
// coalescer feeds the filter array, timer drives its decay sweeps
module spike_rate_unit (
  input  logic                                  clk,
  input  logic                                  reset,
  input  spike_filter_pkg::spike_tag_t          spike_in,
  input  logic                                  spike_valid,
  output logic                                  spike_ready,
  input  spike_filter_pkg::filter_cfg_t         cfg,
  input  logic [spike_filter_pkg::period_w-1:0] update_period,
  output spike_filter_pkg::filter_out_t         rate_out,
  output logic                                  rate_valid,
  input  logic                                  rate_ready
);
  import spike_filter_pkg::*;

  // coalesced runs into the array
  tag_ct_t run;
  logic run_valid;
  logic run_ready;

  logic update_pulse;

  tag_coalescer coalescer (
    .clk         (clk),
    .reset       (reset),
    .spike_in    (spike_in),
    .spike_valid (spike_valid),
    .spike_ready (spike_ready),
    .run         (run),
    .run_valid   (run_valid),
    .run_ready   (run_ready)
  );

  update_timer timer (
    .clk           (clk),
    .reset         (reset),
    .update_period (update_period),
    .update_pulse  (update_pulse)
  );

  spike_filter_array filters (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .run_valid    (run_valid),
    .run_ready    (run_ready),
    .update_pulse (update_pulse),
    .cfg          (cfg),
    .rate_out     (rate_out),
    .rate_valid   (rate_valid),
    .rate_ready   (rate_ready)
  );

endmodule

`default_nettype wire

// ==== hdl/spike_filter_array.sv ====
`timescale 1ns/100ps
`default_nettype none

// one exponential low-pass filter per tag, state held in ram
// spikes add increment_constant * ct, a decay sweep scales by decay_constant
module spike_filter_array (
  input  logic                            clk,
  input  logic                            reset,
  input  spike_filter_pkg::tag_ct_t       run,
  input  logic                            run_valid,
  output logic                            run_ready,
  input  logic                            update_pulse,
  input  spike_filter_pkg::filter_cfg_t   cfg,
  output spike_filter_pkg::filter_out_t   rate_out,
  output logic                            rate_valid,
  input  logic                            rate_ready
);
  import spike_filter_pkg::*;

  typedef enum logic [2:0] {
    st_clear,
    st_ready,
    st_pre2,
    st_pre1,
    st_sweep,
    st_post2,
    st_post1
  } ctl_state_t;

  typedef enum logic [1:0] {
    op_nop,
    op_inc,
    op_dec
  } op_t;

  // memory ports
  logic mem_rd_en;
  filt_idx_t mem_rd_addr;
  logic [state_w-1:0] mem_rd_data;
  logic mem_wr_en;
  filt_idx_t mem_wr_addr;
  logic [state_w-1:0] mem_wr_data;

  filter_state_mem mem (
    .clk     (clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_en   (mem_rd_en),
    .rd_addr (mem_rd_addr),
    .rd_data (mem_rd_data)
  );

  ////////////////////////////////////////
  // stage 1, control fsm

  ctl_state_t state;
  ctl_state_t next_state;
  // clear address during st_clear, sweep index during st_sweep
  filt_idx_t filt_idx;
  filt_idx_t next_filt_idx;
  logic [filt_idx_w:0] filt_idx_p1;
  logic pulse_pending;
  logic go_sweep;
  logic run_fire;
  logic advance;

  // every pipeline register holds while the output is stalled
  assign advance = rate_ready;
  assign go_sweep = pulse_pending || update_pulse;
  assign filt_idx_p1 = filt_idx + 1'b1;

  // runs only in st_ready, and not when a sweep is due
  assign run_ready = advance && (state == st_ready) && !go_sweep;
  assign run_fire = run_valid && run_ready;

  always_comb begin
    next_state = state;
    next_filt_idx = filt_idx;
    case (state)
      st_clear: begin
        // zero one word per clock, not held by the stall
        next_filt_idx = filt_idx + 1'b1;
        if (filt_idx == filt_idx_w'(max_filts - 1))
          next_state = st_post2;
      end
      st_ready: begin
        if (advance && go_sweep)
          next_state = st_pre2;
      end
      st_pre2: begin
        if (advance)
          next_state = st_pre1;
      end
      st_pre1: begin
        if (advance) begin
          next_filt_idx = '0;
          // no filters in use gives an empty sweep
          next_state = (cfg.filts_used == '0) ? st_post2 : st_sweep;
        end
      end
      st_sweep: begin
        if (advance) begin
          if (filt_idx_p1 < cfg.filts_used)
            next_filt_idx = filt_idx_p1[filt_idx_w-1:0];
          else
            next_state = st_post2;
        end
      end
      st_post2: begin
        if (advance)
          next_state = st_post1;
      end
      st_post1: begin
        if (advance)
          next_state = st_ready;
      end
      default: next_state = st_clear;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= st_clear;
      filt_idx <= '0;
      pulse_pending <= 1'b0;
    end else begin
      state <= next_state;
      filt_idx <= next_filt_idx;
      // keep a pulse that lands while busy or stalled
      if (state == st_ready && advance && go_sweep)
        pulse_pending <= 1'b0;
      else if (update_pulse)
        pulse_pending <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // stage 2, issue op and memory read

  op_t s2_next_op;
  filt_idx_t s2_next_idx;
  op_t s2_op;
  filt_idx_t s2_idx;
  logic [ct_w-1:0] s2_ct;

  always_comb begin
    s2_next_op = op_nop;
    s2_next_idx = filt_idx;
    if (state == st_sweep) begin
      s2_next_op = op_dec;
    end else if (run_fire && ({1'b0, run.tag} < cfg.filts_used)) begin
      // tags beyond filts_used are accepted and dropped here
      s2_next_op = op_inc;
      s2_next_idx = run.tag;
    end
  end

  // memory registers the address, so it is fed from the stage 2 inputs
  assign mem_rd_en = advance && (s2_next_op != op_nop);
  assign mem_rd_addr = s2_next_idx;

  ////////////////////////////////////////
  // stage 3, writeback compute and rate output

  op_t s3_op;
  filt_idx_t s3_idx;
  logic [ct_w-1:0] s3_ct;
  logic [state_w-1:0] s3_state;

  // last three writebacks, still in flight to the ram
  logic s4_valid;
  logic s5_valid;
  logic s6_valid;
  filter_out_t s4_wb;
  filter_out_t s5_wb;
  filter_out_t s6_wb;

  logic [state_w-1:0] cur_state;
  logic [inc_prod_w-1:0] inc_mult;
  logic [state_w-1:0] inc_wb;
  logic [dec_prod_w-1:0] dec_mult;
  logic [state_w-1:0] dec_wb;
  logic [state_w-1:0] wb_state;

  // newest pending write to the same filter wins over the ram read
  always_comb begin
    if (s4_valid && s4_wb.filt_idx == s3_idx)
      cur_state = s4_wb.filt_state;
    else if (s5_valid && s5_wb.filt_idx == s3_idx)
      cur_state = s5_wb.filt_state;
    else if (s6_valid && s6_wb.filt_idx == s3_idx)
      cur_state = s6_wb.filt_state;
    else
      cur_state = s3_state;
  end

  // increment, keep the low bits of ct * constant
  assign inc_mult = cfg.increment_constant * s3_ct;
  assign inc_wb = cur_state + inc_mult[state_w-1:0];

  // decay, 18.36 product realigned back to 18.9
  assign dec_mult = cfg.decay_constant * cur_state;
  assign dec_wb = dec_mult[dec_frac_w - frac_w +: state_w];

  assign wb_state = (s3_op == op_dec) ? dec_wb : inc_wb;

  // report the state before decay
  assign rate_valid = (s3_op == op_dec);
  assign rate_out.filt_idx = s3_idx;
  assign rate_out.filt_state = cur_state;

  ////////////////////////////////////////
  // stage 4, memory write
  // the ram input register is the stage 4 register

  always_comb begin
    if (state == st_clear) begin
      mem_wr_en = 1'b1;
      mem_wr_addr = filt_idx;
      mem_wr_data = '0;
    end else begin
      mem_wr_en = advance && (s3_op != op_nop);
      mem_wr_addr = s3_idx;
      mem_wr_data = wb_state;
    end
  end

  ////////////////////////////////////////
  // pipeline registers

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      s2_op <= op_nop;
      s3_op <= op_nop;
      s4_valid <= 1'b0;
      s5_valid <= 1'b0;
      s6_valid <= 1'b0;
    end else if (advance) begin
      s2_op <= s2_next_op;
      s3_op <= s2_op;
      s4_valid <= (s3_op != op_nop);
      s5_valid <= s4_valid;
      s6_valid <= s5_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s2_idx <= s2_next_idx;
      s2_ct <= run.ct;
      s3_idx <= s2_idx;
      s3_ct <= s2_ct;
      s3_state <= mem_rd_data;
      s4_wb.filt_idx <= s3_idx;
      s4_wb.filt_state <= wb_state;
      s5_wb <= s4_wb;
      s6_wb <= s5_wb;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/update_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

// periodic one-clock pulse that starts a decay sweep
module update_timer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [spike_filter_pkg::period_w-1:0] update_period,
  output logic                                  update_pulse
);
  import spike_filter_pkg::*;

  // clocks left in the current period, zero means not loaded
  logic [period_w-1:0] remain;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      remain <= '0;
      update_pulse <= 1'b0;
    end else if (update_period == '0) begin
      // zero period stops the timer
      remain <= '0;
      update_pulse <= 1'b0;
    end else if (remain <= period_w'(1)) begin
      // terminal count or first load
      remain <= update_period;
      update_pulse <= (remain == period_w'(1));
    end else begin
      remain <= remain - 1'b1;
      update_pulse <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tag_coalescer.sv ====
`timescale 1ns/100ps
`default_nettype none

// merges back-to-back spikes of one tag into a (tag, count) record
module tag_coalescer (
  input  logic                          clk,
  input  logic                          reset,
  input  spike_filter_pkg::spike_tag_t  spike_in,
  input  logic                          spike_valid,
  output logic                          spike_ready,
  output spike_filter_pkg::tag_ct_t     run,
  output logic                          run_valid,
  input  logic                          run_ready
);
  import spike_filter_pkg::*;

  // run being accumulated
  tag_ct_t pend;
  logic pend_valid;

  // low for the first clock out of reset
  logic live;

  logic out_free;
  logic spike_fire;
  logic same_tag;
  logic close_run;

  // output register can take a new run this cycle
  assign out_free = !run_valid || run_ready;
  assign spike_ready = live && out_free;
  assign spike_fire = spike_valid && spike_ready;
  assign same_tag = pend_valid && (spike_in.tag == pend.tag);

  // close on input idle, on saturation, or on a new tag
  assign close_run = pend_valid && out_free &&
                     (!spike_valid ||
                      (pend.ct == ct_w'(max_ct)) ||
                      (spike_fire && !same_tag));

  ////////////////////////////////////////
  // control

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      live <= 1'b0;
      pend_valid <= 1'b0;
      run_valid <= 1'b0;
    end else begin
      live <= 1'b1;
      if (spike_fire)
        pend_valid <= 1'b1;
      else if (close_run)
        pend_valid <= 1'b0;
      // released run shows up the cycle after it closes
      if (close_run)
        run_valid <= 1'b1;
      else if (run_ready)
        run_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // payload

  always_ff @(posedge clk) begin
    if (close_run)
      run <= pend;
    if (spike_fire) begin
      pend.tag <= spike_in.tag;
      // same tag extends the run unless it was just closed at max_ct
      if (same_tag && !close_run)
        pend.ct <= pend.ct + 1'b1;
      else
        pend.ct <= ct_w'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/filter_state_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

// simple dual-port state ram, one write port and one read port
module filter_state_mem (
  input  logic                                   clk,
  input  logic                                   wr_en,
  input  spike_filter_pkg::filt_idx_t            wr_addr,
  input  logic [spike_filter_pkg::state_w-1:0]   wr_data,
  input  logic                                   rd_en,
  input  spike_filter_pkg::filt_idx_t            rd_addr,
  output logic [spike_filter_pkg::state_w-1:0]   rd_data
);
  import spike_filter_pkg::*;

  logic [state_w-1:0] mem [max_filts];

  // write port input register
  logic wr_en_q;
  filt_idx_t wr_addr_q;
  logic [state_w-1:0] wr_data_q;

  // write lands one clock after the request
  always_ff @(posedge clk) begin
    wr_en_q <= wr_en;
    wr_addr_q <= wr_addr;
    wr_data_q <= wr_data;
    if (wr_en_q)
      mem[wr_addr_q] <= wr_data_q;
  end

  // read data valid the cycle after rd_en, held while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/spike_filter_pkg.sv ====
`default_nettype none

package spike_filter_pkg;

  ////////////////////////////////////////
  // sizes

  // filter index and memory address
  localparam int filt_idx_w = 10;
  localparam int max_filts = 1 << filt_idx_w;

  // filter state is 18.9 fixed point
  localparam int state_w = 27;
  localparam int frac_w = 9;

  // spike count per coalesced run
  localparam int ct_w = 10;
  localparam int max_ct = (1 << ct_w) - 1;

  // decay sweep period in clocks
  localparam int period_w = 20;

  // increment product is count times 18.9 constant
  localparam int inc_prod_w = state_w + ct_w;
  // decay product is 0.27 times 18.9, giving 18.36
  localparam int dec_prod_w = 2 * state_w;
  localparam int dec_frac_w = frac_w + state_w;

  ////////////////////////////////////////
  // types

  typedef logic [filt_idx_w-1:0] filt_idx_t;

  typedef struct packed {
    filt_idx_t tag;
  } spike_tag_t;

  typedef struct packed {
    filt_idx_t tag;
    logic [ct_w-1:0] ct;
  } tag_ct_t;

  typedef struct packed {
    filt_idx_t filt_idx;
    logic [state_w-1:0] filt_state;
  } filter_out_t;

  // one extra bit so that all max_filts filters can be enabled
  typedef struct packed {
    logic [filt_idx_w:0] filts_used;
    logic [state_w-1:0] increment_constant;
    logic [state_w-1:0] decay_constant;
  } filter_cfg_t;

endpackage

`default_nettype wire
